/* all.f */
+incdir+source
source/bus_pkg.sv
source/bus_req_slot.sv
source/bus_wb8_master.sv
source/bus_rsp_slot.sv
source/wb8_ram.sv
source/bus_subsys_top.sv
verification/bus_subsys_tb.sv

/* source/bus_defines.svh */
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// cpu side address and data widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// byte ram decodes only the low address bits
`define RAM_ADDR_W 8

`endif

/* source/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	// load/store operations seen on the request channel
	typedef enum logic [2:0] {
		op_readb,   // byte, sign extended
		op_readbu,  // byte, zero extended
		op_readh,   // halfword, sign extended
		op_readhu,  // halfword, zero extended
		op_readw,
		op_writeb,
		op_writeh,
		op_writew
	} bus_op_t;

	// wishbone master sequencer
	typedef enum logic [1:0] {
		st_idle,
		st_active,
		st_done
	} master_state_t;

endpackage

`default_nettype wire

/* source/bus_req_slot.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bus_defines.svh"

module bus_req_slot (
	input  wire                    CLK_I,
	input  wire                    RST_I,
	input  wire                    req_valid,
	input  wire bus_pkg::bus_op_t  req_op,
	input  wire [`BUS_ADDR_W-1:0]  req_addr,
	input  wire [`BUS_DATA_W-1:0]  req_wdata,
	input  wire                    iss_ready,
	output logic                   req_ready,
	output logic                   iss_valid,
	output bus_pkg::bus_op_t       iss_op,
	output logic [`BUS_ADDR_W-1:0] iss_addr,
	output logic [`BUS_DATA_W-1:0] iss_wdata
);

	logic full;
	logic load;
	logic issue;

	assign req_ready = !full;
	assign iss_valid = full;
	assign load      = req_valid && req_ready;
	assign issue     = iss_valid && iss_ready;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			full <= 1'b0;
		end else begin
			full <= load || (full && !issue); // refill wins over drain
		end
	end

	// held request
	always_ff @(posedge CLK_I) begin
		if (load) begin
			iss_op    <= req_op;
			iss_addr  <= req_addr;
			iss_wdata <= req_wdata;
		end
	end

	a_op_held: assert property (@(posedge CLK_I) disable iff (RST_I)
		iss_valid && !iss_ready |=> $stable(iss_op));

endmodule

`default_nettype wire

/* source/bus_rsp_slot.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bus_defines.svh"

module bus_rsp_slot (
	input  wire                    CLK_I,
	input  wire                    RST_I,
	input  wire                    cmp_valid,
	input  wire [`BUS_DATA_W-1:0]  cmp_data,
	input  wire                    rsp_ready,
	output logic                   cmp_ready,
	output logic                   rsp_valid,
	output logic [`BUS_DATA_W-1:0] rsp_data
);

	logic full;
	logic load;
	logic drain;

	assign cmp_ready = !full;
	assign rsp_valid = full;
	assign load      = cmp_valid && cmp_ready;
	assign drain     = rsp_valid && rsp_ready;

	always_ff @(posedge CLK_I) begin
		if (RST_I)
			full <= 1'b0;
		else
			full <= load || (full && !drain);
	end

	always_ff @(posedge CLK_I) begin
		if (load)
			rsp_data <= cmp_data;  // held until the cpu takes it
	end

	// response frozen while the cpu stalls
	a_data_held: assert property (@(posedge CLK_I) disable iff (RST_I)
		rsp_valid && !rsp_ready |=> rsp_data === $past(rsp_data));

endmodule

`default_nettype wire

/* source/bus_subsys_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bus_defines.svh"

module bus_subsys_top (
	input  wire                    CLK_I,
	input  wire                    RST_I,
	input  wire                    req_valid,
	input  wire bus_pkg::bus_op_t  req_op,
	input  wire [`BUS_ADDR_W-1:0]  req_addr,
	input  wire [`BUS_DATA_W-1:0]  req_wdata,
	input  wire                    rsp_ready,
	output logic                   req_ready,
	output logic                   rsp_valid,
	output logic [`BUS_DATA_W-1:0] rsp_data
);

	import bus_pkg::*;

	// issue channel
	logic                   iss_valid;
	logic                   iss_ready;
	bus_op_t                iss_op;
	logic [`BUS_ADDR_W-1:0] iss_addr;
	logic [`BUS_DATA_W-1:0] iss_wdata;

	// completion channel
	logic                   cmp_valid;
	logic                   cmp_ready;
	logic [`BUS_DATA_W-1:0] cmp_data;

	// wishbone
	logic [`BUS_ADDR_W-1:0] adr;
	logic [7:0]             dat_w;
	logic [7:0]             dat_r;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic                   ack;

	bus_req_slot u_req_slot (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.iss_ready (iss_ready),
		.req_ready (req_ready),
		.iss_valid (iss_valid),
		.iss_op    (iss_op),
		.iss_addr  (iss_addr),
		.iss_wdata (iss_wdata)
	);

	bus_wb8_master u_master (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.iss_valid (iss_valid),
		.iss_op    (iss_op),
		.iss_addr  (iss_addr),
		.iss_wdata (iss_wdata),
		.dat_r     (dat_r),
		.ack       (ack),
		.cmp_ready (cmp_ready),
		.iss_ready (iss_ready),
		.adr       (adr),
		.dat_w     (dat_w),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.cmp_valid (cmp_valid),
		.cmp_data  (cmp_data)
	);

	bus_rsp_slot u_rsp_slot (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.cmp_valid (cmp_valid),
		.cmp_data  (cmp_data),
		.rsp_ready (rsp_ready),
		.cmp_ready (cmp_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data)
	);

	wb8_ram u_ram (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.adr   (adr),
		.dat_w (dat_w),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.dat_r (dat_r),
		.ack   (ack)
	);

endmodule

`default_nettype wire

/* source/bus_wb8_master.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bus_defines.svh"

module bus_wb8_master (
	input  wire                    CLK_I,
	input  wire                    RST_I,
	input  wire                    iss_valid,
	input  wire bus_pkg::bus_op_t  iss_op,
	input  wire [`BUS_ADDR_W-1:0]  iss_addr,
	input  wire [`BUS_DATA_W-1:0]  iss_wdata,
	input  wire [7:0]              dat_r,
	input  wire                    ack,
	input  wire                    cmp_ready,
	output logic                   iss_ready,
	output logic [`BUS_ADDR_W-1:0] adr,
	output logic [7:0]             dat_w,
	output logic                   cyc,
	output logic                   stb,
	output logic                   we,
	output logic                   cmp_valid,
	output logic [`BUS_DATA_W-1:0] cmp_data
);

	import bus_pkg::*;

	master_state_t state;

	logic [2:0] stb_cnt;   // strobes issued
	logic [2:0] ack_cnt;   // acks received
	logic [2:0] byte_cnt;  // 1, 2 or 4
	logic       wr;
	logic       sext;

	logic [`BUS_ADDR_W-1:0] addr_q;
	logic [`BUS_DATA_W-1:0] wdata_q;
	logic [`BUS_DATA_W-1:0] result;

	logic [2:0] dec_cnt;
	logic       dec_wr;
	logic       dec_sext;
	logic       issue;
	logic       sgn;

	// decode of the incoming operation
	always_comb begin
		dec_cnt  = 3'd1;
		dec_wr   = 1'b0;
		dec_sext = 1'b0;
		case (iss_op)
			op_readb:  dec_sext = 1'b1;
			op_readbu: dec_cnt  = 3'd1;
			op_readh: begin
				dec_cnt  = 3'd2;
				dec_sext = 1'b1;
			end
			op_readhu: dec_cnt = 3'd2;
			op_readw:  dec_cnt = 3'd4;  // all lanes overwritten, sign irrelevant
			op_writeb: dec_wr  = 1'b1;
			op_writeh: begin
				dec_cnt = 3'd2;
				dec_wr  = 1'b1;
			end
			op_writew: begin
				dec_cnt = 3'd4;
				dec_wr  = 1'b1;
			end
			default: dec_cnt = 3'd1;
		endcase
	end

	assign iss_ready = (state == st_idle);
	assign issue     = iss_valid && iss_ready;
	assign cyc       = (state == st_active);
	assign stb       = cyc && (stb_cnt != byte_cnt);
	assign we        = cyc && wr;
	assign adr       = addr_q + {{(`BUS_ADDR_W-3){1'b0}}, stb_cnt};  // little endian byte walk
	assign dat_w     = wdata_q[{stb_cnt[1:0], 3'b000} +: 8];
	assign cmp_valid = (state == st_done);
	assign cmp_data  = result;
	assign sgn       = dat_r[7] && sext;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state   <= st_idle;
			stb_cnt <= 3'd0;
			ack_cnt <= 3'd0;
		end else begin
			case (state)
				st_idle: begin
					if (iss_valid) begin
						state   <= st_active;
						stb_cnt <= 3'd0;
						ack_cnt <= 3'd0;
					end
				end
				st_active: begin
					if (stb)
						stb_cnt <= stb_cnt + 3'd1;
					if (ack) begin
						ack_cnt <= ack_cnt + 3'd1;
						if (ack_cnt + 3'd1 == byte_cnt)
							state <= st_done;  // last ack, drop cyc
					end
				end
				st_done: begin
					if (cmp_ready)
						state <= st_idle;  // result handed over
				end
				default: state <= st_idle;
			endcase
		end
	end

	// operation context, captured once per issue
	always_ff @(posedge CLK_I) begin
		if (issue) begin
			byte_cnt <= dec_cnt;
			wr       <= dec_wr;
			sext     <= dec_sext;
			addr_q   <= iss_addr;
			wdata_q  <= iss_wdata;
		end
	end

	// read data merge, first ack seeds the extension
	always_ff @(posedge CLK_I) begin
		if (cyc && ack && !wr) begin
			case (ack_cnt[1:0])
				2'd0:    result        <= {{24{sgn}}, dat_r};
				2'd1:    result[31:8]  <= {{16{sgn}}, dat_r};
				2'd2:    result[23:16] <= dat_r;
				default: result[31:24] <= dat_r;
			endcase
		end
	end

	a_stb_in_cyc: assert property (@(posedge CLK_I) disable iff (RST_I) stb |-> cyc);

	// slave must not answer outside a cycle
	a_ack_in_cyc: assert property (@(posedge CLK_I) disable iff (RST_I) ack |-> cyc);

	a_ack_le_stb: assert property (@(posedge CLK_I) disable iff (RST_I) ack_cnt <= stb_cnt);

endmodule

`default_nettype wire

/* source/wb8_ram.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bus_defines.svh"

module wb8_ram (
	input  wire                   CLK_I,
	input  wire                   RST_I,
	input  wire [`BUS_ADDR_W-1:0] adr,
	input  wire [7:0]             dat_w,
	input  wire                   cyc,
	input  wire                   stb,
	input  wire                   we,
	output logic [7:0]            dat_r,
	output logic                  ack
);

	localparam int DEPTH = 2 ** `RAM_ADDR_W;

	logic [7:0] mem [0:DEPTH-1];
	logic [`RAM_ADDR_W-1:0] idx;
	logic access;

	assign idx    = adr[`RAM_ADDR_W-1:0];  // upper bits ignored
	assign access = cyc && stb;

	always_ff @(posedge CLK_I) begin
		if (access) begin
			if (we)
				mem[idx] <= dat_w;
			else
				dat_r <= mem[idx];
		end
	end

	// no wait states, every strobe acked next cycle
	always_ff @(posedge CLK_I) begin
		if (RST_I)
			ack <= 1'b0;
		else
			ack <= access;
	end

endmodule

`default_nettype wire

/* verification/bus_subsys_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bus_defines.svh"

module bus_subsys_tb;

	import bus_pkg::*;

	localparam int DEPTH = 2 ** `RAM_ADDR_W;

	logic                   CLK_I;
	logic                   RST_I;
	logic                   req_valid;
	bus_op_t                req_op;
	logic [`BUS_ADDR_W-1:0] req_addr;
	logic [`BUS_DATA_W-1:0] req_wdata;
	logic                   rsp_ready;
	logic                   req_ready;
	logic                   rsp_valid;
	logic [`BUS_DATA_W-1:0] rsp_data;

	logic [7:0]  model_mem [0:DEPTH-1];  // byte image of the ram
	logic [31:0] lfsr_state;
	bus_op_t     pend_op [$];             // requests not yet accepted
	logic [31:0] pend_addr [$];
	logic [31:0] pend_wdata [$];
	logic [31:0] exp_data [$];            // responses still owed
	logic        exp_read [$];
	string       exp_name [$];
	string       test_name;
	logic        throttle;
	int          n_req;
	int          n_rsp;

	bus_subsys_top UUT (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.rsp_ready (rsp_ready),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data)
	);

	always #50 CLK_I = ~CLK_I;

	// galois lfsr stepped once per bit taken
	function automatic logic next_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v[k] = next_bit();
		return v;
	endfunction

	function automatic int op_bytes(input bus_op_t op);
		case (op)
			op_readh, op_readhu, op_writeh: return 2;
			op_readw, op_writew:            return 4;
			default:                        return 1;
		endcase
	endfunction

	// little endian fetch from the model then extension by operation
	function automatic logic [31:0] model_read(input bus_op_t op, input logic [31:0] addr);
		logic [31:0] w;
		for (int k = 0; k < 4; k++)
			w[8*k +: 8] = model_mem[(addr + k) % DEPTH];
		case (op)
			op_readb:  return {{24{w[7]}}, w[7:0]};
			op_readbu: return {24'h0, w[7:0]};
			op_readh:  return {{16{w[15]}}, w[15:0]};
			op_readhu: return {16'h0, w[15:0]};
			default:   return w;
		endcase
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic queue_req(input bus_op_t op, input logic [31:0] addr, input logic [31:0] wd);
		pend_op.push_back(op);
		pend_addr.push_back(addr);
		pend_wdata.push_back(wd);
	endtask

	task automatic accept_request();
		bus_op_t     op;
		logic [31:0] addr;
		logic [31:0] wd;
		op   = pend_op.pop_front();
		addr = pend_addr.pop_front();
		wd   = pend_wdata.pop_front();
		n_req++;
		exp_name.push_back($sformatf("%s %s @%0h", test_name, op.name(), addr));
		if (op >= op_writeb) begin
			for (int k = 0; k < op_bytes(op); k++)
				model_mem[(addr + k) % DEPTH] = wd[8*k +: 8];  // operations finish in order
			exp_read.push_back(1'b0);
			exp_data.push_back(32'h0);
		end else begin
			exp_read.push_back(1'b1);
			exp_data.push_back(model_read(op, addr));
		end
	endtask

	task automatic check_response();
		logic [31:0] exp;
		logic        is_rd;
		string       name;
		assert (exp_read.size() != 0)
		else abort_run("response arrived with no request outstanding");
		exp   = exp_data.pop_front();
		is_rd = exp_read.pop_front();
		name  = exp_name.pop_front();
		n_rsp++;
		if (is_rd) begin
			assert (rsp_data === exp)
			else abort_run($sformatf("Mismatch %s expected %08h actual %08h",
				name, exp, rsp_data));
		end
	endtask

	// sample mid cycle and drive 1 ns after the edge
	task automatic step_cycle();
		logic took;
		took = 1'b0;
		@(negedge CLK_I);
		if (req_valid && req_ready) begin
			accept_request();
			took = 1'b1;
		end
		if (rsp_valid && rsp_ready)
			check_response();
		@(posedge CLK_I);
		#1;
		if (pend_op.size() == 0) begin
			req_valid = 1'b0;
		end else if (took || !req_valid) begin
			req_valid = throttle ? (rand_bits(2) != 0) : 1'b1;  // random gaps
			req_op    = pend_op[0];
			req_addr  = pend_addr[0];
			req_wdata = pend_wdata[0];
		end
		rsp_ready = throttle ? rand_bits(1) : 1'b1;
	endtask

	task automatic run_phase(input string name, input logic thr, input int limit);
		int cycles;
		test_name = name;
		throttle  = thr;
		cycles    = 0;
		while (pend_op.size() != 0 || req_valid || n_rsp != n_req) begin
			step_cycle();
			cycles++;
			if (cycles > limit)
				abort_run($sformatf("phase %s did not finish within %0d cycles", name, limit));
		end
	endtask

	initial begin
		logic [31:0] wd;
		logic [31:0] a;
		bus_op_t     op;
		CLK_I      = 1'b0;
		RST_I      = 1'b1;
		req_valid  = 1'b0;
		req_op     = op_readw;
		req_addr   = '0;
		req_wdata  = '0;
		rsp_ready  = 1'b0;
		lfsr_state = 32'd99;
		throttle   = 1'b0;
		n_req      = 0;
		n_rsp      = 0;
		test_name  = "reset";
		repeat (4) @(posedge CLK_I);
		#1;
		RST_I = 1'b0;

		@(negedge CLK_I);
		assert (req_ready === 1'b1 && rsp_valid === 1'b0)
		else abort_run("after reset the request port is not ready or a response is pending");

		for (int i = 0; i < 20; i += 4)  // window plus word overhang
			queue_req(op_writew, i, rand_bits(32));
		run_phase("preload", 1'b0, 200);

		for (int i = 0; i < 16; i++) begin
			queue_req(op_writew, i, rand_bits(32));
			queue_req(op_readw, i, 32'h0);
		end
		run_phase("word_rw", 1'b0, 1000);

		for (int i = 0; i < 16; i++) begin
			wd     = rand_bits(32);
			wd[7]  = i[0];  // cover both sign bits
			wd[15] = i[1];
			queue_req(op_writew, i, wd);
			queue_req(op_readb, i, 32'h0);
			queue_req(op_readbu, i, 32'h0);
			queue_req(op_readh, i, 32'h0);
			queue_req(op_readhu, i, 32'h0);
		end
		run_phase("extend", 1'b0, 2000);

		for (int i = 0; i < 32; i++) begin
			op = rand_bits(1) ? op_writeh : op_writeb;
			a  = rand_bits(4);
			queue_req(op, a, rand_bits(32));
			queue_req(op_readw, a, 32'h0);
		end
		run_phase("partial_write", 1'b0, 2000);

		for (int i = 0; i < 300; i++) begin
			op = bus_op_t'(rand_bits(3));
			a  = rand_bits(4);
			queue_req(op, a, rand_bits(32));
		end
		run_phase("random_bp", 1'b1, 20000);

		repeat (10) step_cycle();  // a stray response would trip the empty queue check
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
